/* design/boot_pkg.sv */
`default_nettype none

package boot_pkg;

  // serial bit period in clock cycles
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned CLK_CNT_W    = $clog2(CLKS_PER_BIT);

  // sample points inside one bit period
  localparam logic [CLK_CNT_W-1:0] BIT_LAST = CLK_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CLK_CNT_W-1:0] BIT_MID  = CLK_CNT_W'((CLKS_PER_BIT - 1) / 2);

  // one serial frame carries a byte
  localparam int unsigned BYTE_W    = 8;
  localparam int unsigned BIT_IDX_W = $clog2(BYTE_W);
  localparam logic [BIT_IDX_W-1:0] LAST_BIT_IDX = BIT_IDX_W'(BYTE_W - 1);

  // four bytes make one program word
  localparam int unsigned BYTES_PER_WORD = 4;
  localparam int unsigned BYTE_CNT_W     = $clog2(BYTES_PER_WORD);
  localparam logic [BYTE_CNT_W-1:0] LAST_BYTE_IDX = BYTE_CNT_W'(BYTES_PER_WORD - 1);

  // aligned word that ends the program, never stored
  localparam logic [31:0] END_MARKER = 32'h0000_0fff;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  typedef enum logic [1:0] {
    LD_COLLECT,
    LD_WRITE,
    LD_DONE
  } loader_state_e;

endpackage

`default_nettype wire

/* design/iccm_pkg.sv */
`default_nettype none

package iccm_pkg;

  // bank layout, low address bits pick the bank
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_SEL_W = 2;
  localparam int unsigned BANK_AW    = 6;
  localparam int unsigned BANK_DEPTH = 2 ** BANK_AW;

  // whole memory is 256 words
  localparam int unsigned ICCM_AW = 8;
  localparam int unsigned DATA_W  = 32;

  // write command from the loader
  typedef struct packed {
    logic               we;
    logic [ICCM_AW-1:0] addr;
    logic [DATA_W-1:0]  data;
  } iccm_wr_t;

  // fetch request, plain level strobe
  typedef struct packed {
    logic               req;
    logic [ICCM_AW-1:0] addr;
  } iccm_req_t;

  // bank or fetch response
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } iccm_rsp_t;

endpackage

`default_nettype wire

/* design/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic       clock,
  input  logic       rst_n_i,
  input  logic       rx_serial_i,
  output logic       rx_dv_o,
  output logic [7:0] rx_byte_o
);

  import boot_pkg::*;

  logic                 rx_meta_q;
  logic                 rx_sync_q;
  uart_state_e          state_q;
  logic [CLK_CNT_W-1:0] clk_cnt_q;
  logic [BIT_IDX_W-1:0] bit_idx_q;
  logic [BYTE_W-1:0]    data_q;
  logic                 sample_bit;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // end of a full bit period while shifting data
  assign sample_bit = (state_q == UART_DATA) && (clk_cnt_q == BIT_LAST);

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      rx_dv_o   <= 1'b0;
    end else begin
      rx_dv_o <= 1'b0;
      case (state_q)
        UART_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          // confirm the start bit at its middle
          if (clk_cnt_q == BIT_MID) begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == BIT_LAST) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == LAST_BIT_IDX) begin
              bit_idx_q <= '0;
              state_q   <= UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          if (clk_cnt_q == BIT_LAST) begin
            clk_cnt_q <= '0;
            // low stop bit means a broken frame, no strobe
            rx_dv_o   <= rx_sync_q;
            state_q   <= UART_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= UART_IDLE;
        end
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clock) begin
    if (sample_bit) begin
      data_q[bit_idx_q] <= rx_sync_q;
    end
  end

  assign rx_byte_o = data_q;

endmodule

`default_nettype wire

/* design/iccm_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module iccm_controller (
  input  logic               clock,
  input  logic               rst_n_i,
  input  logic               rx_dv_i,
  input  logic [7:0]         rx_byte_i,
  output iccm_pkg::iccm_wr_t wr_o,
  output logic               core_hold_o
);

  import boot_pkg::*;
  import iccm_pkg::*;

  loader_state_e         state_q;
  logic [BYTE_CNT_W-1:0] byte_cnt_q;
  logic [DATA_W-1:0]     word_q;
  logic [ICCM_AW-1:0]    addr_q;
  logic [DATA_W-1:0]     word_next;
  logic                  byte_take;
  logic                  word_done;

  // little endian, newest byte enters at the top
  assign word_next = {rx_byte_i, word_q[DATA_W-1:BYTE_W]};

  // bytes only count while still loading
  assign byte_take = rx_dv_i && (state_q == LD_COLLECT);
  assign word_done = byte_take && (byte_cnt_q == LAST_BYTE_IDX);

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q    <= LD_COLLECT;
      byte_cnt_q <= '0;
      addr_q     <= '0;
    end else begin
      case (state_q)
        LD_COLLECT: begin
          if (byte_take) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          // marker only checked on a word boundary
          if (word_done) begin
            state_q <= (word_next == END_MARKER) ? LD_DONE : LD_WRITE;
          end
        end
        LD_WRITE: begin
          // single write pulse, then next word slot
          addr_q  <= addr_q + 1'b1;
          state_q <= LD_COLLECT;
        end
        LD_DONE: begin
          state_q <= LD_DONE;
        end
        default: begin
          state_q <= LD_COLLECT;
        end
      endcase
    end
  end

  // word assembly
  always_ff @(posedge clock) begin
    if (byte_take) begin
      word_q <= word_next;
    end
  end

  assign wr_o.we   = (state_q == LD_WRITE);
  assign wr_o.addr = addr_q;
  assign wr_o.data = word_q;

  // core stays in reset until the marker is seen
  assign core_hold_o = (state_q != LD_DONE);

endmodule

`default_nettype wire

/* design/iccm_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module iccm_bank (
  input  logic                            clock,
  input  logic                            rst_n_i,
  input  logic [iccm_pkg::BANK_SEL_W-1:0] bank_id_i,
  input  iccm_pkg::iccm_wr_t              wr_i,
  input  iccm_pkg::iccm_req_t             req_i,
  output iccm_pkg::iccm_rsp_t             rsp_o
);

  import iccm_pkg::*;

  logic [DATA_W-1:0]  mem_q [BANK_DEPTH];
  logic [BANK_AW-1:0] wr_row;
  logic [BANK_AW-1:0] rd_row;
  logic               wr_hit;
  logic               rd_hit;
  logic               rvalid_q;
  logic [DATA_W-1:0]  rdata_q;

  // row inside this bank sits above the bank field
  assign wr_row = wr_i.addr[ICCM_AW-1:BANK_SEL_W];
  assign rd_row = req_i.addr[ICCM_AW-1:BANK_SEL_W];

  assign wr_hit = wr_i.we && (wr_i.addr[BANK_SEL_W-1:0] == bank_id_i);
  // a write to this bank wins over a fetch
  assign rd_hit = req_i.req && (req_i.addr[BANK_SEL_W-1:0] == bank_id_i) && !wr_hit;

  always_ff @(posedge clock) begin
    if (wr_hit) begin
      mem_q[wr_row] <= wr_i.data;
    end
    if (rd_hit) begin
      rdata_q <= mem_q[rd_row];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_hit;
    end
  end

  assign rsp_o.valid = rvalid_q;
  assign rsp_o.data  = rdata_q;

endmodule

`default_nettype wire

/* design/iccm_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module iccm_read_mux (
  input  iccm_pkg::iccm_rsp_t [iccm_pkg::NUM_BANKS-1:0] bank_rsp_i,
  output iccm_pkg::iccm_rsp_t                           fetch_rsp_o
);

  import iccm_pkg::*;

  logic [NUM_BANKS-1:0] valid_vec;
  logic [DATA_W-1:0]    data_or;

  // only one bank answers in any cycle
  always_comb begin
    data_or = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      valid_vec[b] = bank_rsp_i[b].valid;
      if (bank_rsp_i[b].valid) begin
        data_or = data_or | bank_rsp_i[b].data;
      end
    end
  end

  assign fetch_rsp_o.valid = |valid_vec;
  assign fetch_rsp_o.data  = data_or;

endmodule

`default_nettype wire

/* design/iccm_boot_top.sv */
`timescale 1ns/1ps
`default_nettype none

module iccm_boot_top (
  input  logic                clock,
  input  logic                rst_n_i,
  input  logic                uart_rx_i,
  input  iccm_pkg::iccm_req_t fetch_req_i,
  output iccm_pkg::iccm_rsp_t fetch_rsp_o,
  output logic                core_hold_o
);

  import iccm_pkg::*;

  logic                        rx_dv;
  logic [7:0]                  rx_byte;
  iccm_wr_t                    iccm_wr;
  iccm_rsp_t [NUM_BANKS-1:0]   bank_rsp;

  // serial program loader
  uart_rx u_uart_rx (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .rx_serial_i (uart_rx_i),
    .rx_dv_o     (rx_dv),
    .rx_byte_o   (rx_byte)
  );

  iccm_controller u_iccm_ctrl (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .rx_dv_i     (rx_dv),
    .rx_byte_i   (rx_byte),
    .wr_o        (iccm_wr),
    .core_hold_o (core_hold_o)
  );

  // word-interleaved banks, each sees every write and fetch
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    iccm_bank u_bank (
      .clock     (clock),
      .rst_n_i   (rst_n_i),
      .bank_id_i (BANK_SEL_W'(b)),
      .wr_i      (iccm_wr),
      .req_i     (fetch_req_i),
      .rsp_o     (bank_rsp[b])
    );
  end

  iccm_read_mux u_read_mux (
    .bank_rsp_i  (bank_rsp),
    .fetch_rsp_o (fetch_rsp_o)
  );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // 4 ns period
  localparam real HALF_PERIOD = 2.0;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_iccm_boot.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_iccm_boot;

  import boot_pkg::*;
  import iccm_pkg::*;

  localparam int unsigned MEM_WORDS   = 2 ** ICCM_AW;
  localparam int unsigned EXTRA_BYTES = 12;
  localparam int unsigned BURST_LEN   = 24;
  localparam int unsigned MARGIN      = 2000;

  logic      clk;
  logic      rst_n;
  logic      uart_rx;
  iccm_req_t fetch_req;
  iccm_rsp_t fetch_rsp;
  logic      core_hold;

  // reference memory and expected loader state
  logic [DATA_W-1:0]  model_mem [MEM_WORDS];
  logic [ICCM_AW-1:0] model_addr;
  logic               exp_hold;
  logic [ICCM_AW-1:0] fetch_q [$];

  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned prog1_len;
  int unsigned prog2_len;

  tb_clock_gen u_clk_gen (
    .clk_o (clk)
  );

  iccm_boot_top i_dut (
    .clock       (clk),
    .rst_n_i     (rst_n),
    .uart_rx_i   (uart_rx),
    .fetch_req_i (fetch_req),
    .fetch_rsp_o (fetch_rsp),
    .core_hold_o (core_hold)
  );

  // one clock, then settle just past the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) step();
  endtask

  task automatic compare_values(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    fetch_req = '0;
    uart_rx   = 1'b1;
    wait_cycles(4);
    rst_n      = 1'b1;
    model_addr = '0;
    exp_hold   = 1'b1;
    compare_values("reset hold", 32'(exp_hold), 32'(core_hold));
    compare_values("reset valid", 32'(0), 32'(fetch_rsp.valid));
  endtask

  // start bit, 8 data bits lsb first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [7:0] bits;
    bits    = b;
    uart_rx = 1'b0;
    wait_cycles(CLKS_PER_BIT);
    for (int i = 0; i < 8; i++) begin
      uart_rx = bits[0];
      bits    = bits >> 1;
      wait_cycles(CLKS_PER_BIT);
    end
    uart_rx = 1'b1;
    wait_cycles(CLKS_PER_BIT);
  endtask

  task automatic send_word_bytes(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      send_byte(8'(w >> (8 * i)));
    end
  endtask

  task automatic send_word(input string name, input logic [31:0] w);
    send_word_bytes(w);
    model_mem[model_addr] = w;
    model_addr = model_addr + 1'b1;
    compare_values({name, " hold"}, 32'(exp_hold), 32'(core_hold));
  endtask

  task automatic send_marker(input string name);
    int unsigned waited;
    send_word_bytes(END_MARKER);
    waited = 0;
    // release may trail the stop bit by up to 2 cycles
    while (core_hold && waited < 2) begin
      step();
      waited++;
    end
    exp_hold = 1'b0;
    compare_values({name, " release"}, 32'(exp_hold), 32'(core_hold));
  endtask

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = $urandom();
    while (w == END_MARKER) begin
      w = $urandom();
    end
    return w;
  endfunction

  task automatic load_random(input string name, input int unsigned n);
    for (int i = 0; i < int'(n); i++) begin
      send_word(name, rand_word());
    end
  endtask

  // marker bytes straddling two words at a byte offset of 1 to 3
  task automatic send_unaligned_marker(input int unsigned offset);
    logic [63:0] pair;
    string       name;
    pair = {32'($urandom()), 32'($urandom())};
    pair = pair & ~(64'hffff_ffff << (8 * offset));
    pair = pair | (64'(END_MARKER) << (8 * offset));
    name = $sformatf("unaligned marker offset %0d", offset);
    send_word(name, pair[31:0]);
    send_word(name, pair[63:32]);
  endtask

  task automatic queue_shuffled(input int unsigned n);
    logic [ICCM_AW-1:0] tmp;
    int unsigned        j;
    fetch_q.delete();
    for (int i = 0; i < int'(n); i++) begin
      fetch_q.push_back(ICCM_AW'(i));
    end
    for (int i = int'(n) - 1; i > 0; i--) begin
      j          = $urandom_range(i, 0);
      tmp        = fetch_q[i];
      fetch_q[i] = fetch_q[j];
      fetch_q[j] = tmp;
    end
  endtask

  task automatic check_rsp(input string name, input logic exp_valid,
                           input logic [ICCM_AW-1:0] addr);
    compare_values({name, " valid"}, 32'(exp_valid), 32'(fetch_rsp.valid));
    if (exp_valid) begin
      compare_values($sformatf("%s data @%0h", name, addr), model_mem[addr], fetch_rsp.data);
    end
  endtask

  // back to back requests, each response due one cycle later
  task automatic run_fetches(input string name);
    logic               prev_req;
    logic [ICCM_AW-1:0] prev_addr;
    prev_req  = 1'b0;
    prev_addr = '0;
    foreach (fetch_q[i]) begin
      step();
      check_rsp(name, prev_req, prev_addr);
      fetch_req.req  = 1'b1;
      fetch_req.addr = fetch_q[i];
      prev_req       = 1'b1;
      prev_addr      = fetch_q[i];
    end
    step();
    check_rsp(name, prev_req, prev_addr);
    fetch_req = '0;
    step();
    check_rsp(name, 1'b0, '0);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hada4_545c));
    err_cnt   = 0;
    check_cnt = 0;
    cycle_cnt = 0;
    rst_n     = 1'b0;
    uart_rx   = 1'b1;
    fetch_req = '0;
    prog1_len = $urandom_range(120, 40);
    prog2_len = $urandom_range(30, 12);
    // serial bytes dominate, fetches and resets are small
    cycle_limit = ((prog1_len + 1) * 4 + EXTRA_BYTES + (prog2_len + 1) * 4)
                  * 10 * CLKS_PER_BIT + 2 * prog1_len + BURST_LEN + MARGIN;

    apply_reset();
    load_random("load", prog1_len);
    send_marker("load marker");

    queue_shuffled(prog1_len);
    run_fetches("readback");

    // first eight addresses walk every bank, the rest are random
    fetch_q.delete();
    for (int i = 0; i < int'(BURST_LEN); i++) begin
      if (i < 8) begin
        fetch_q.push_back(ICCM_AW'(i));
      end else begin
        fetch_q.push_back(ICCM_AW'($urandom_range(prog1_len - 1, 0)));
      end
    end
    run_fetches("interleave");

    // reload, memory keeps the tail of the first program
    apply_reset();
    for (int unsigned off = 1; off < 4; off++) begin
      send_unaligned_marker(off);
    end
    load_random("reload", prog2_len - 6);
    send_marker("reload marker");

    // late bytes must leave the first program's tail alone
    for (int i = 0; i < int'(EXTRA_BYTES); i++) begin
      send_byte(8'($urandom()));
      compare_values("hold after marker", 32'(exp_hold), 32'(core_hold));
    end
    queue_shuffled(prog1_len);
    run_fetches("reload readback");

    $display("checks %0d errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
design/boot_pkg.sv
design/iccm_pkg.sv
design/uart_rx.sv
design/iccm_controller.sv
design/iccm_bank.sv
design/iccm_read_mux.sv
design/iccm_boot_top.sv
sim/tb_clock_gen.sv
sim/tb_iccm_boot.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --timing
TOP       := tb_iccm_boot
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
